/* csr_file.f */
source/csr_pkg.sv
source/csr_write_arbiter.sv
source/csr_mode_regs.sv
source/csr_timer.sv
source/csr_save_bank.sv
source/csr_file.sv
verification/csr_file_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f csr_file.f --top-module csr_file_tb -o csr_file_sim
./obj_dir/csr_file_sim > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
    exit 1
fi

/* verification/csr_file_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file_tb;

    import csr_pkg::*;

    localparam int          SAVE_COUNT   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED    = 32'd37002;
    localparam logic [31:0] LFSR_TAPS    = 32'hb4bc_d35c;

    localparam int ACT_WR1  = 0;
    localparam int ACT_WR2  = 1;
    localparam int ACT_BOTH = 2;
    localparam int ACT_EXCP = 3;
    localparam int ACT_ERTN = 4;
    localparam int ACT_WAIT = 5;
    localparam int ACT_READ = 6;
    localparam int ACT_HWI  = 7;
    localparam int ACT_PIN  = 8;

    // output selected by the addr column of a pin row
    localparam logic [ADDR_W-1:0] PIN_HAS_INT = 14'd0;
    localparam logic [ADDR_W-1:0] PIN_PLV     = 14'd1;
    localparam logic [ADDR_W-1:0] PIN_EENTRY  = 14'd2;
    localparam logic [ADDR_W-1:0] PIN_ERA     = 14'd3;
    localparam logic [ADDR_W-1:0] PIN_TID     = 14'd4;

    localparam logic [ECODE_W-1:0] EXC_CODE    = 6'h0b;
    localparam logic [DATA_W-1:0]  EXC_ERA     = 32'h1c00_0040;
    localparam logic [DATA_W-1:0]  ESTAT_EXC   = 32'(EXC_CODE) << ECODE_LO;
    localparam logic [HWI_W-1:0]   HWI_PATTERN = 9'h155;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  wr1_we_i;
    logic [ADDR_W-1:0]     wr1_addr_i;
    logic [DATA_W-1:0]     wr1_data_i;
    logic                  wr2_we_i;
    logic [ADDR_W-1:0]     wr2_addr_i;
    logic [DATA_W-1:0]     wr2_data_i;
    logic [ADDR_W-1:0]     rd_addr_i;
    logic [DATA_W-1:0]     rdata_o;
    logic                  excp_flush_i;
    logic                  ertn_flush_i;
    logic [ECODE_W-1:0]    ecode_i;
    logic [ESUBCODE_W-1:0] esubcode_i;
    logic [DATA_W-1:0]     era_i;
    logic                  va_error_i;
    logic [DATA_W-1:0]     bad_va_i;
    logic [HWI_W-1:0]      hw_int_i;
    logic [1:0]            plv_o;
    logic                  has_int_o;
    logic [DATA_W-1:0]     eentry_o;
    logic [DATA_W-1:0]     era_o;
    logic [DATA_W-1:0]     tid_o;

    // stimulus table, one entry per row in each queue
    string             row_name [$];
    int                row_act  [$];
    logic [ADDR_W-1:0] row_addr [$];
    logic [DATA_W-1:0] row_data [$];
    logic [DATA_W-1:0] row_exp  [$];

    logic [31:0] lfsr_q      = LFSR_SEED;
    int          cycle_cnt   = 0;
    int          cycle_limit = RESET_CYCLES + 200;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    logic [DATA_W-1:0] rnd [6];

    csr_file #(
        .SAVE_COUNT (SAVE_COUNT)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .wr1_we_i     (wr1_we_i),
        .wr1_addr_i   (wr1_addr_i),
        .wr1_data_i   (wr1_data_i),
        .wr2_we_i     (wr2_we_i),
        .wr2_addr_i   (wr2_addr_i),
        .wr2_data_i   (wr2_data_i),
        .rd_addr_i    (rd_addr_i),
        .rdata_o      (rdata_o),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .va_error_i   (va_error_i),
        .bad_va_i     (bad_va_i),
        .hw_int_i     (hw_int_i),
        .plv_o        (plv_o),
        .has_int_o    (has_int_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o),
        .tid_o        (tid_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // one LFSR step per bit of the word
    task automatic rand_word(output logic [DATA_W-1:0] w);
        for (int b = 0; b < DATA_W; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[b]   = lfsr_q[0];
        end
    endtask

    task automatic add_row(input string name, input int act, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        row_name.push_back(name);
        row_act.push_back(act);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(exp);
        if (act == ACT_WAIT) begin
            cycle_limit += int'(data);
        end else begin
            cycle_limit += 2;
        end
    endtask

    function automatic logic [DATA_W-1:0] pin_value(input logic [ADDR_W-1:0] pin);
        case (pin)
            PIN_HAS_INT: return {31'b0, has_int_o};
            PIN_PLV:     return {30'b0, plv_o};
            PIN_EENTRY:  return eentry_o;
            PIN_ERA:     return era_o;
            PIN_TID:     return tid_o;
            default:     return 32'hdead_beef;
        endcase
    endfunction

    task automatic report_result(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
        if (act === exp) begin
            pass_cnt++;
            $display("ok    %s", name);
        end else begin
            fail_cnt++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apply_row(input int i);
        case (row_act[i])
            ACT_WR1, ACT_WR2, ACT_BOTH: begin
                @(posedge clk);
                wr1_we_i   <= (row_act[i] != ACT_WR2);
                wr2_we_i   <= (row_act[i] != ACT_WR1);
                wr1_addr_i <= row_addr[i];
                wr2_addr_i <= row_addr[i];
                wr1_data_i <= row_data[i];
                // port 2 carries a different word so a wrong winner shows
                wr2_data_i <= (row_act[i] == ACT_BOTH) ? ~row_data[i] : row_data[i];
                @(posedge clk);
                wr1_we_i <= 1'b0;
                wr2_we_i <= 1'b0;
            end
            ACT_EXCP, ACT_ERTN: begin
                @(posedge clk);
                excp_flush_i <= (row_act[i] == ACT_EXCP);
                ertn_flush_i <= (row_act[i] == ACT_ERTN);
                ecode_i      <= row_addr[i][ECODE_W-1:0];
                era_i        <= row_data[i];
                @(negedge clk);
                report_result(row_name[i], row_exp[i], {30'b0, plv_o});
                @(posedge clk);
                excp_flush_i <= 1'b0;
                ertn_flush_i <= 1'b0;
            end
            ACT_WAIT: begin
                repeat (int'(row_data[i])) @(posedge clk);
            end
            ACT_READ, ACT_HWI: begin
                @(posedge clk);
                rd_addr_i <= row_addr[i];
                if (row_act[i] == ACT_HWI) begin
                    hw_int_i <= row_data[i][HWI_W-1:0];
                end
                @(negedge clk);
                report_result(row_name[i], row_exp[i], rdata_o);
            end
            ACT_PIN: begin
                @(negedge clk);
                report_result(row_name[i], row_exp[i], pin_value(row_addr[i]));
            end
            default: begin
                fail_cnt++;
                $display("row %0d has an unknown action", i);
            end
        endcase
    endtask

    initial begin
        rst          <= 1'b1;
        wr1_we_i     <= 1'b0;
        wr1_addr_i   <= '0;
        wr1_data_i   <= '0;
        wr2_we_i     <= 1'b0;
        wr2_addr_i   <= '0;
        wr2_data_i   <= '0;
        rd_addr_i    <= '0;
        excp_flush_i <= 1'b0;
        ertn_flush_i <= 1'b0;
        ecode_i      <= '0;
        esubcode_i   <= '0;
        era_i        <= '0;
        va_error_i   <= 1'b0;
        bad_va_i     <= '0;
        hw_int_i     <= '0;

        for (int k = 0; k < 6; k++) begin
            rand_word(rnd[k]);
        end

        add_row("crmd_reset",    ACT_READ, ADDR_CRMD,   '0, CRMD_RESET);
        add_row("has_int_reset", ACT_PIN,  PIN_HAS_INT, '0, 32'h0);
        add_row("plv_reset",     ACT_PIN,  PIN_PLV,     '0, 32'h0);
        add_row("tcfg_reset",    ACT_READ, ADDR_TCFG,   '0, 32'h0);

        add_row("wr_save0", ACT_WR1, ADDR_SAVE0,         rnd[0], '0);
        add_row("wr_save1", ACT_WR2, ADDR_SAVE0 + 14'd1, rnd[1], '0);
        add_row("wr_save2", ACT_WR1, ADDR_SAVE0 + 14'd2, rnd[2], '0);
        add_row("wr_save3", ACT_WR2, ADDR_SAVE0 + 14'd3, rnd[3], '0);
        add_row("wr_tid",   ACT_WR2, ADDR_TID,           rnd[4], '0);
        add_row("save0_port1", ACT_READ, ADDR_SAVE0,         '0, rnd[0]);
        add_row("save1_port2", ACT_READ, ADDR_SAVE0 + 14'd1, '0, rnd[1]);
        add_row("save2_port1", ACT_READ, ADDR_SAVE0 + 14'd2, '0, rnd[2]);
        add_row("save3_port2", ACT_READ, ADDR_SAVE0 + 14'd3, '0, rnd[3]);
        add_row("tid_read",    ACT_READ, ADDR_TID,           '0, rnd[4]);
        add_row("tid_pin",     ACT_PIN,  PIN_TID,            '0, rnd[4]);
        add_row("wr_both",       ACT_BOTH, ADDR_SAVE0 + 14'd1, rnd[5], '0);
        add_row("both_port1_wins", ACT_READ, ADDR_SAVE0 + 14'd1, '0, rnd[5]);
        add_row("unknown_addr",  ACT_READ, 14'h3ff, '0, 32'h0);

        // PLV 3 with IE and DA set
        add_row("wr_crmd",         ACT_WR1,  ADDR_CRMD, 32'h0000_000f, '0);
        add_row("crmd_user",       ACT_READ, ADDR_CRMD, '0, 32'h0000_000f);
        add_row("plv_in_excp",     ACT_EXCP, {8'b0, EXC_CODE}, EXC_ERA, 32'h0);
        add_row("crmd_after_excp", ACT_READ, ADDR_CRMD,  '0, 32'h0000_0008);
        add_row("prmd_after_excp", ACT_READ, ADDR_PRMD,  '0, 32'h0000_0007);
        add_row("estat_ecode",     ACT_READ, ADDR_ESTAT, '0, ESTAT_EXC);
        add_row("era_read",        ACT_READ, ADDR_ERA,   '0, EXC_ERA);
        add_row("era_pin",         ACT_PIN,  PIN_ERA,    '0, EXC_ERA);
        add_row("plv_in_ertn",     ACT_ERTN, '0, '0, 32'h3);
        add_row("crmd_after_ertn", ACT_READ, ADDR_CRMD,  '0, 32'h0000_000f);

        add_row("wr_eentry",   ACT_WR2,  ADDR_EENTRY, 32'hffff_ffff, '0);
        add_row("eentry_read", ACT_READ, ADDR_EENTRY, '0, 32'hffff_ffc0);
        add_row("eentry_pin",  ACT_PIN,  PIN_EENTRY,  '0, 32'hffff_ffc0);

        // INITVAL 3, one-shot, enabled
        add_row("wr_tcfg",          ACT_WR1,  ADDR_TCFG,  32'h0000_000d, '0);
        add_row("wait_count",       ACT_WAIT, '0, 32'd11, '0);
        add_row("ti_before_expiry", ACT_READ, ADDR_ESTAT, '0, ESTAT_EXC);
        add_row("wait_expiry",      ACT_WAIT, '0, 32'd1, '0);
        add_row("ti_after_expiry",  ACT_READ, ADDR_ESTAT, '0, ESTAT_EXC | (32'h1 << TI_BIT));
        add_row("tval_stopped",     ACT_READ, ADDR_TVAL,  '0, 32'hffff_ffff);
        add_row("wr_ectl_ti",       ACT_WR1,  ADDR_ECTL,  32'h0000_0800, '0);
        add_row("has_int_timer",    ACT_PIN,  PIN_HAS_INT, '0, 32'h1);
        add_row("wr_ticlr",         ACT_WR2,  ADDR_TICLR, 32'h0000_0001, '0);
        add_row("ti_cleared",       ACT_READ, ADDR_ESTAT, '0, ESTAT_EXC);
        add_row("has_int_cleared",  ACT_PIN,  PIN_HAS_INT, '0, 32'h0);

        add_row("hwi_not_yet", ACT_HWI,  ADDR_ESTAT, 32'(HWI_PATTERN), ESTAT_EXC);
        add_row("hwi_sampled", ACT_READ, ADDR_ESTAT, '0,
                ESTAT_EXC | (32'(HWI_PATTERN) << HWI_LO));
        add_row("has_int_hwi_masked", ACT_PIN, PIN_HAS_INT, '0, 32'h0);
        // IS bit 4 is line 2, set in the pattern
        add_row("wr_ectl_line2",   ACT_WR1, ADDR_ECTL, 32'h0000_0010, '0);
        add_row("has_int_line_on", ACT_PIN, PIN_HAS_INT, '0, 32'h1);
        add_row("wr_ectl_line1",   ACT_WR1, ADDR_ECTL, 32'h0000_0008, '0);
        add_row("has_int_line_off", ACT_PIN, PIN_HAS_INT, '0, 32'h0);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr1_we_i,
    input  logic [csr_pkg::ADDR_W-1:0]     wr1_addr_i,
    input  logic [csr_pkg::DATA_W-1:0]     wr1_data_i,
    input  logic                           wr2_we_i,
    input  logic [csr_pkg::ADDR_W-1:0]     wr2_addr_i,
    input  logic [csr_pkg::DATA_W-1:0]     wr2_data_i,
    input  logic [csr_pkg::ADDR_W-1:0]     rd_addr_i,
    output logic [csr_pkg::DATA_W-1:0]     rdata_o,
    input  logic                           excp_flush_i,
    input  logic                           ertn_flush_i,
    input  logic [csr_pkg::ECODE_W-1:0]    ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0] esubcode_i,
    input  logic [csr_pkg::DATA_W-1:0]     era_i,
    input  logic                           va_error_i,
    input  logic [csr_pkg::DATA_W-1:0]     bad_va_i,
    input  logic [csr_pkg::HWI_W-1:0]      hw_int_i,
    output logic [1:0]                     plv_o,
    output logic                           has_int_o,
    output logic [csr_pkg::DATA_W-1:0]     eentry_o,
    output logic [csr_pkg::DATA_W-1:0]     era_o,
    output logic [csr_pkg::DATA_W-1:0]     tid_o
);

    import csr_pkg::*;

    localparam int SAVE_IDX_W = $clog2(SAVE_COUNT);

    logic              wr_we;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] crmd;
    logic [DATA_W-1:0] prmd;
    logic [DATA_W-1:0] ectl;
    logic [DATA_W-1:0] estat;
    logic [DATA_W-1:0] badv;
    logic [DATA_W-1:0] tcfg;
    logic [DATA_W-1:0] tval;
    logic [DATA_W-1:0] save_rdata;
    logic              ti_pending;
    logic [ADDR_W-1:0] rd_off;
    logic              save_hit;

    csr_write_arbiter u_arbiter (
        .wr1_we_i   (wr1_we_i),
        .wr1_addr_i (wr1_addr_i),
        .wr1_data_i (wr1_data_i),
        .wr2_we_i   (wr2_we_i),
        .wr2_addr_i (wr2_addr_i),
        .wr2_data_i (wr2_data_i),
        .wr_we_o    (wr_we),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data)
    );

    csr_mode_regs u_mode_regs (
        .clk          (clk),
        .rst          (rst),
        .wr_we_i      (wr_we),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .va_error_i   (va_error_i),
        .bad_va_i     (bad_va_i),
        .hw_int_i     (hw_int_i),
        .ti_pending_i (ti_pending),
        .crmd_o       (crmd),
        .prmd_o       (prmd),
        .ectl_o       (ectl),
        .estat_o      (estat),
        .era_o        (era_o),
        .badv_o       (badv),
        .eentry_o     (eentry_o),
        .plv_o        (plv_o),
        .has_int_o    (has_int_o)
    );

    csr_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .wr_we_i      (wr_we),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .tcfg_o       (tcfg),
        .tval_o       (tval),
        .ti_pending_o (ti_pending)
    );

    csr_save_bank #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_save_bank (
        .clk        (clk),
        .rst        (rst),
        .wr_we_i    (wr_we),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .rd_index_i (rd_off[SAVE_IDX_W-1:0]),
        .save_o     (save_rdata),
        .tid_o      (tid_o)
    );

    assign rd_off   = rd_addr_i - ADDR_SAVE0;
    assign save_hit = (rd_addr_i >= ADDR_SAVE0) && (rd_off < ADDR_W'(SAVE_COUNT));

    // unknown addresses and TICLR read zero
    always_comb begin
        case (rd_addr_i)
            ADDR_CRMD:   rdata_o = crmd;
            ADDR_PRMD:   rdata_o = prmd;
            ADDR_ECTL:   rdata_o = ectl;
            ADDR_ESTAT:  rdata_o = estat;
            ADDR_ERA:    rdata_o = era_o;
            ADDR_BADV:   rdata_o = badv;
            ADDR_EENTRY: rdata_o = eentry_o;
            ADDR_TID:    rdata_o = tid_o;
            ADDR_TCFG:   rdata_o = tcfg;
            ADDR_TVAL:   rdata_o = tval;
            default:     rdata_o = save_hit ? save_rdata : '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csr_save_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_save_bank #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_we_i,
    input  logic [csr_pkg::ADDR_W-1:0]    wr_addr_i,
    input  logic [csr_pkg::DATA_W-1:0]    wr_data_i,
    input  logic [$clog2(SAVE_COUNT)-1:0] rd_index_i,
    output logic [csr_pkg::DATA_W-1:0]    save_o,
    output logic [csr_pkg::DATA_W-1:0]    tid_o
);

    import csr_pkg::*;

    localparam int IDX_W = $clog2(SAVE_COUNT);

    logic [DATA_W-1:0] save_q [SAVE_COUNT];
    logic [DATA_W-1:0] tid_q;
    logic [ADDR_W-1:0] save_off;
    logic              save_we;

    // window SAVE0 .. SAVE0+SAVE_COUNT-1
    assign save_off = wr_addr_i - ADDR_SAVE0;
    assign save_we  = wr_we_i && (wr_addr_i >= ADDR_SAVE0)
                      && (save_off < ADDR_W'(SAVE_COUNT));

    always_ff @(posedge clk) begin
        if (save_we) begin
            save_q[save_off[IDX_W-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q <= '0;
        end else if (wr_we_i && (wr_addr_i == ADDR_TID)) begin
            tid_q <= wr_data_i;
        end
    end

    assign save_o = save_q[rd_index_i];
    assign tid_o  = tid_q;

endmodule

`default_nettype wire

/* source/csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_we_i,
    input  logic [csr_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [csr_pkg::DATA_W-1:0] wr_data_i,
    output logic [csr_pkg::DATA_W-1:0] tcfg_o,
    output logic [csr_pkg::DATA_W-1:0] tval_o,
    output logic                       ti_pending_o
);

    import csr_pkg::*;

    logic [DATA_W-1:0] tcfg_q;
    logic [DATA_W-1:0] tval_q;
    logic              timer_en;
    logic              ti_q;
    logic              tcfg_we;
    logic              ticlr_we;
    logic              expire;

    assign tcfg_we  = wr_we_i && (wr_addr_i == ADDR_TCFG);
    assign ticlr_we = wr_we_i && (wr_addr_i == ADDR_TICLR) && wr_data_i[TICLR_CLR];
    assign expire   = timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q <= '0;
        end else if (tcfg_we) begin
            tcfg_q <= wr_data_i;
        end
    end

    // one-shot mode stops at expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            timer_en <= wr_data_i[TCFG_EN];
        end else if (expire) begin
            timer_en <= tcfg_q[TCFG_PERIODIC];
        end
    end

    // INITVAL sits at bit 2 so the load is INITVAL*4
    always_ff @(posedge clk) begin
        if (rst) begin
            tval_q <= '0;
        end else if (tcfg_we) begin
            tval_q <= {wr_data_i[DATA_W-1:INITVAL_LO], {INITVAL_LO{1'b0}}};
        end else if (expire) begin
            if (tcfg_q[TCFG_PERIODIC]) begin
                tval_q <= {tcfg_q[DATA_W-1:INITVAL_LO], {INITVAL_LO{1'b0}}};
            end else begin
                tval_q <= '1;
            end
        end else if (timer_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_we) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    assign tcfg_o       = tcfg_q;
    assign tval_o       = tval_q;
    assign ti_pending_o = ti_q;

    // countdown never runs without TCFG.EN
    en_from_tcfg_a: assert property (@(posedge clk) disable iff (rst)
        timer_en |-> tcfg_q[TCFG_EN]);

endmodule

`default_nettype wire

/* source/csr_mode_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_mode_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_we_i,
    input  logic [csr_pkg::ADDR_W-1:0]     wr_addr_i,
    input  logic [csr_pkg::DATA_W-1:0]     wr_data_i,
    input  logic                           excp_flush_i,
    input  logic                           ertn_flush_i,
    input  logic [csr_pkg::ECODE_W-1:0]    ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0] esubcode_i,
    input  logic [csr_pkg::DATA_W-1:0]     era_i,
    input  logic                           va_error_i,
    input  logic [csr_pkg::DATA_W-1:0]     bad_va_i,
    input  logic [csr_pkg::HWI_W-1:0]      hw_int_i,
    input  logic                           ti_pending_i,
    output logic [csr_pkg::DATA_W-1:0]     crmd_o,
    output logic [csr_pkg::DATA_W-1:0]     prmd_o,
    output logic [csr_pkg::DATA_W-1:0]     ectl_o,
    output logic [csr_pkg::DATA_W-1:0]     estat_o,
    output logic [csr_pkg::DATA_W-1:0]     era_o,
    output logic [csr_pkg::DATA_W-1:0]     badv_o,
    output logic [csr_pkg::DATA_W-1:0]     eentry_o,
    output logic [1:0]                     plv_o,
    output logic                           has_int_o
);

    import csr_pkg::*;

    logic [DATA_W-1:0]            crmd_q;
    logic [DATA_W-1:0]            prmd_q;
    logic [DATA_W-1:0]            ectl_q;
    logic [HWI_LO-1:0]            swi_q;
    logic [HWI_W-1:0]             hwi_q;
    logic [ECODE_W-1:0]           ecode_q;
    logic [ESUBCODE_W-1:0]        esubcode_q;
    logic [DATA_W-1:0]            era_q;
    logic [DATA_W-1:0]            badv_q;
    logic [DATA_W-1:EENTRY_ALIGN] eentry_q;
    logic                         crmd_we;
    logic                         prmd_we;
    logic                         ectl_we;
    logic                         estat_we;
    logic                         era_we;
    logic                         badv_we;
    logic                         eentry_we;

    assign crmd_we   = wr_we_i && (wr_addr_i == ADDR_CRMD);
    assign prmd_we   = wr_we_i && (wr_addr_i == ADDR_PRMD);
    assign ectl_we   = wr_we_i && (wr_addr_i == ADDR_ECTL);
    assign estat_we  = wr_we_i && (wr_addr_i == ADDR_ESTAT);
    assign era_we    = wr_we_i && (wr_addr_i == ADDR_ERA);
    assign badv_we   = wr_we_i && (wr_addr_i == ADDR_BADV);
    assign eentry_we = wr_we_i && (wr_addr_i == ADDR_EENTRY);

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET;
        end else if (excp_flush_i) begin
            crmd_q[PLV_HI:PLV_LO] <= '0;
            crmd_q[IE_BIT]        <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd_q[PLV_HI:PLV_LO] <= prmd_q[PPLV_HI:PPLV_LO];
            crmd_q[IE_BIT]        <= prmd_q[PIE_BIT];
        end else if (crmd_we) begin
            crmd_q[PLV_HI:PLV_LO]   <= wr_data_i[PLV_HI:PLV_LO];
            crmd_q[IE_BIT]          <= wr_data_i[IE_BIT];
            crmd_q[DA_BIT]          <= wr_data_i[DA_BIT];
            crmd_q[PG_BIT]          <= wr_data_i[PG_BIT];
            crmd_q[DATF_HI:DATF_LO] <= wr_data_i[DATF_HI:DATF_LO];
            crmd_q[DATM_HI:DATM_LO] <= wr_data_i[DATM_HI:DATM_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (excp_flush_i) begin
            prmd_q[PPLV_HI:PPLV_LO] <= crmd_q[PLV_HI:PLV_LO];
            prmd_q[PIE_BIT]         <= crmd_q[IE_BIT];
        end else if (prmd_we) begin
            prmd_q[PPLV_HI:PPLV_LO] <= wr_data_i[PPLV_HI:PPLV_LO];
            prmd_q[PIE_BIT]         <= wr_data_i[PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q <= '0;
        end else if (ectl_we) begin
            ectl_q[IS_HI:IS_LO] <= wr_data_i[IS_HI:IS_LO];
        end
    end

    // hw lines land in IS one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            swi_q      <= '0;
            hwi_q      <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hwi_q <= hw_int_i;
            if (estat_we) begin
                swi_q <= wr_data_i[HWI_LO-1:0];
            end
            if (excp_flush_i) begin
                ecode_q    <= ecode_i;
                esubcode_q <= esubcode_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush_i) begin
            era_q <= era_i;
        end else if (era_we) begin
            era_q <= wr_data_i;
        end
        if (badv_we) begin
            badv_q <= wr_data_i;
        end else if (va_error_i) begin
            badv_q <= bad_va_i;
        end
        if (eentry_we) begin
            eentry_q <= wr_data_i[DATA_W-1:EENTRY_ALIGN];
        end
    end

    always_comb begin
        estat_o                               = '0;
        estat_o[HWI_LO-1:0]                   = swi_q;
        estat_o[HWI_LO +: HWI_W]              = hwi_q;
        estat_o[TI_BIT]                       = ti_pending_i;
        estat_o[ECODE_LO +: ECODE_W]          = ecode_q;
        estat_o[ESUBCODE_LO +: ESUBCODE_W]    = esubcode_q;
    end

    // level seen by the pipeline after this edge
    always_comb begin
        if (excp_flush_i) begin
            plv_o = '0;
        end else if (ertn_flush_i) begin
            plv_o = prmd_q[PPLV_HI:PPLV_LO];
        end else if (crmd_we) begin
            plv_o = wr_data_i[PLV_HI:PLV_LO];
        end else begin
            plv_o = crmd_q[PLV_HI:PLV_LO];
        end
    end

    assign has_int_o = (|(ectl_q[IS_HI:IS_LO] & estat_o[IS_HI:IS_LO])) & crmd_q[IE_BIT];
    assign crmd_o    = crmd_q;
    assign prmd_o    = prmd_q;
    assign ectl_o    = ectl_q;
    assign era_o     = era_q;
    assign badv_o    = badv_q;
    assign eentry_o  = {eentry_q, {EENTRY_ALIGN{1'b0}}};

    // exception entry and return come from different pipeline events
    flush_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(excp_flush_i && ertn_flush_i));

endmodule

`default_nettype wire

/* source/csr_write_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_write_arbiter (
    input  logic                       wr1_we_i,
    input  logic [csr_pkg::ADDR_W-1:0] wr1_addr_i,
    input  logic [csr_pkg::DATA_W-1:0] wr1_data_i,
    input  logic                       wr2_we_i,
    input  logic [csr_pkg::ADDR_W-1:0] wr2_addr_i,
    input  logic [csr_pkg::DATA_W-1:0] wr2_data_i,
    output logic                       wr_we_o,
    output logic [csr_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [csr_pkg::DATA_W-1:0] wr_data_o
);

    // port 1 wins and the losing write is dropped
    always_comb begin
        if (wr1_we_i) begin
            wr_we_o   = 1'b1;
            wr_addr_o = wr1_addr_i;
            wr_data_o = wr1_data_i;
        end else if (wr2_we_i) begin
            wr_we_o   = 1'b1;
            wr_addr_o = wr2_addr_i;
            wr_data_o = wr2_data_i;
        end else begin
            wr_we_o   = 1'b0;
            wr_addr_o = '0;
            wr_data_o = '0;
        end
    end

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 14;

    // register addresses
    localparam logic [ADDR_W-1:0] ADDR_CRMD   = 14'h000;
    localparam logic [ADDR_W-1:0] ADDR_PRMD   = 14'h001;
    localparam logic [ADDR_W-1:0] ADDR_ECTL   = 14'h004;
    localparam logic [ADDR_W-1:0] ADDR_ESTAT  = 14'h005;
    localparam logic [ADDR_W-1:0] ADDR_ERA    = 14'h006;
    localparam logic [ADDR_W-1:0] ADDR_BADV   = 14'h007;
    localparam logic [ADDR_W-1:0] ADDR_EENTRY = 14'h00c;
    localparam logic [ADDR_W-1:0] ADDR_SAVE0  = 14'h030;
    localparam logic [ADDR_W-1:0] ADDR_TID    = 14'h040;
    localparam logic [ADDR_W-1:0] ADDR_TCFG   = 14'h041;
    localparam logic [ADDR_W-1:0] ADDR_TVAL   = 14'h042;
    localparam logic [ADDR_W-1:0] ADDR_TICLR  = 14'h044;

    // crmd fields
    localparam int PLV_LO  = 0;
    localparam int PLV_HI  = 1;
    localparam int IE_BIT  = 2;
    localparam int DA_BIT  = 3;
    localparam int PG_BIT  = 4;
    localparam int DATF_LO = 5;
    localparam int DATF_HI = 6;
    localparam int DATM_LO = 7;
    localparam int DATM_HI = 8;

    // prmd fields
    localparam int PPLV_LO = 0;
    localparam int PPLV_HI = 1;
    localparam int PIE_BIT = 2;

    // estat fields, ectl.LIE shares the IS layout
    localparam int IS_LO       = 0;
    localparam int IS_HI       = 12;
    localparam int HWI_LO      = 2;
    localparam int ECODE_LO    = 16;
    localparam int ESUBCODE_LO = 22;

    // timer fields
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int INITVAL_LO    = 2;
    localparam int TICLR_CLR     = 0;

    localparam int ECODE_W      = 6;
    localparam int ESUBCODE_W   = 9;
    localparam int HWI_W        = 9;
    localparam int TI_BIT       = 11;
    localparam int EENTRY_ALIGN = 6;

    localparam logic [DATA_W-1:0] CRMD_RESET = 32'h0000_0008;

endpackage

`default_nettype wire
